//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - design/mem_stage_pkg.sv
  - design/mem_access_unit.sv
  - design/fence_flush_ctrl.sv
  - design/flush_line_counter.sv
  - design/dmem_bank.sv
  - design/mem_stage.sv
  - design/mem_subsystem_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mem_subsystem.sv

//--- design/dmem_bank.sv
`default_nettype none

module dmem_bank (
    input  wire                          CLK,
    input  wire                          nRST,
    input  wire                          ren,
    input  wire                          wen,
    input  wire mem_stage_pkg::word_t    addr,
    input  wire mem_stage_pkg::word_t    wdata,
    input  wire mem_stage_pkg::byte_en_t byte_en,
    output mem_stage_pkg::word_t         rdata,
    output logic                         busy,
    output logic                         error
);
    import mem_stage_pkg::*;

    word_t                 mem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] idx;
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic                  req;
    logic                  in_range;
    logic                  write_now;

    assign req      = ren || wen;
    assign idx      = addr[DMEM_IDX_W+1:2];
    assign in_range = (addr[31:DMEM_IDX_W+2] == '0);

    // Out-of-range requests error out right away, no wait states
    assign error     = req && !in_range;
    assign busy      = req && in_range && (wait_cnt != WAIT_CNT_W'(DMEM_WAIT));
    assign write_now = wen && in_range && !busy;

    // Valid in the completion cycle
    assign rdata = in_range ? mem[idx] : '0;

    // Wait timer, restarts whenever the request drops or completes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (busy) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // Byte-lane writes at completion
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int w = 0; w < DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (write_now) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Requester has to hold the access until busy releases
    a_addr_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        busy |=> $stable(addr)
    ) else $error("address changed during a wait state");

endmodule

`default_nettype wire

//--- design/fence_flush_ctrl.sv
`default_nettype none

module fence_flush_ctrl (
    input  wire  CLK,
    input  wire  nRST,
    input  wire  ifence,
    input  wire  iflush_done,
    input  wire  dflush_done,
    output logic flush_start,
    output logic fence_stall
);

    typedef enum logic [1:0] {
        IDLE,
        FLUSHING,
        HELD
    } state_t;

    state_t state, state_next;
    logic   i_done, i_done_next;
    logic   d_done, d_done_next;
    logic   i_seen, d_seen;

    // HELD only exits once ifence is low, so ifence high in IDLE is a new fence
    assign flush_start = (state == IDLE) && ifence;
    assign fence_stall = (state == FLUSHING);

    // Done either earlier or right now
    assign i_seen = i_done || iflush_done;
    assign d_seen = d_done || dflush_done;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= IDLE;
            i_done <= 1'b0;
            d_done <= 1'b0;
        end else begin
            state  <= state_next;
            i_done <= i_done_next;
            d_done <= d_done_next;
        end
    end

    always_comb begin
        state_next  = state;
        i_done_next = i_done;
        d_done_next = d_done;
        case (state)
            IDLE: begin
                if (flush_start) begin
                    state_next  = FLUSHING;
                    i_done_next = 1'b0;
                    d_done_next = 1'b0;
                end
            end
            FLUSHING: begin
                i_done_next = i_seen;
                d_done_next = d_seen;
                // Stall ends the cycle after the later done pulse
                if (i_seen && d_seen) begin
                    state_next = ifence ? HELD : IDLE;
                end
            end
            HELD: begin
                if (!ifence) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Caches must only report completion of a flush we started
    a_no_done_in_idle: assert property (
        @(posedge CLK) disable iff (!nRST)
        (state == IDLE) |-> !(iflush_done || dflush_done)
    ) else $error("flush done pulse while no fence is pending");

endmodule

`default_nettype wire

//--- design/flush_line_counter.sv
`default_nettype none

module flush_line_counter (
    input  wire  CLK,
    input  wire  nRST,
    input  wire  icache_flush,
    input  wire  dcache_flush,
    output logic iflush_done,
    output logic dflush_done
);
    import mem_stage_pkg::*;

    // Index 0 is the icache, index 1 the dcache
    logic [FLUSH_CNT_W-1:0] sweep_cnt [2];
    logic [FLUSH_CNT_W-1:0] sweep_len [2];
    logic [1:0]             start;

    assign start        = {dcache_flush, icache_flush};
    assign sweep_len[0] = FLUSH_CNT_W'(FLUSH_LINES);
    assign sweep_len[1] = FLUSH_CNT_W'(2 * FLUSH_LINES);

    // One line per cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 2; i++) begin
                sweep_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (start[i]) begin
                    sweep_cnt[i] <= sweep_len[i];
                end else if (sweep_cnt[i] != '0) begin
                    sweep_cnt[i] <= sweep_cnt[i] - 1'b1;
                end
            end
        end
    end

    // Last line in progress, counter hits zero at this edge
    assign iflush_done = (sweep_cnt[0] == FLUSH_CNT_W'(1));
    assign dflush_done = (sweep_cnt[1] == FLUSH_CNT_W'(1));

    a_no_iflush_restart: assert property (
        @(posedge CLK) disable iff (!nRST)
        icache_flush |-> (sweep_cnt[0] == '0)
    ) else $error("icache flush requested during a sweep");

    a_no_dflush_restart: assert property (
        @(posedge CLK) disable iff (!nRST)
        dcache_flush |-> (sweep_cnt[1] == '0)
    ) else $error("dcache flush requested during a sweep");

endmodule

`default_nettype wire

//--- design/mem_access_unit.sv
`default_nettype none

module mem_access_unit (
    input  wire mem_stage_pkg::access_t access,
    input  wire [1:0]                   addr_low,
    input  wire mem_stage_pkg::word_t   store_data,
    input  wire mem_stage_pkg::word_t   load_word,
    output mem_stage_pkg::byte_en_t     byte_en,
    output mem_stage_pkg::word_t        bus_wdata,
    output logic                        misaligned,
    output mem_stage_pkg::word_t        load_data
);
    import mem_stage_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // Lane enables, little-endian bus
    always_comb begin
        byte_en = '0;
        case (access)
            LB, LBU: begin
                byte_en = 4'b0001 << addr_low;
            end
            LH, LHU: begin
                if (!addr_low[0]) begin
                    byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
                end
            end
            LW: begin
                if (addr_low == 2'b00) begin
                    byte_en = 4'b1111;
                end
            end
            default: begin
                byte_en = '0;
            end
        endcase
    end

    // Alignment check
    always_comb begin
        case (access)
            LH, LHU: misaligned = addr_low[0];
            LW:      misaligned = (addr_low != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end

    // Replicate store data so the memory only needs the lane enables
    always_comb begin
        case (access)
            LB, LBU: bus_wdata = {4{store_data[7:0]}};
            LH, LHU: bus_wdata = {2{store_data[15:0]}};
            LW:      bus_wdata = store_data;
            default: bus_wdata = '0;
        endcase
    end

    // Pick the addressed byte / halfword out of the returned word
    assign load_byte = load_word[{addr_low, 3'b000} +: 8];
    assign load_half = addr_low[1] ? load_word[31:16] : load_word[15:0];

    always_comb begin
        case (access)
            LB:      load_data = {{24{load_byte[7]}}, load_byte};
            LBU:     load_data = {24'h0, load_byte};
            LH:      load_data = {{16{load_half[15]}}, load_half};
            LHU:     load_data = {16'h0, load_half};
            LW:      load_data = load_word;
            default: load_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`default_nettype none

module mem_stage (
    input  wire                          CLK,
    input  wire                          nRST,
    input  wire                          dren,
    input  wire                          dwen,
    input  wire mem_stage_pkg::access_t  access,
    input  wire mem_stage_pkg::word_t    alu_out,
    input  wire mem_stage_pkg::word_t    rs2_data,
    input  wire mem_stage_pkg::word_t    pc4,
    input  wire mem_stage_pkg::word_t    imm_u,
    input  wire mem_stage_pkg::w_sel_t   w_sel,
    input  wire mem_stage_pkg::reg_idx_t rd_in,
    input  wire                          reg_write_in,
    input  wire                          ifence,
    input  wire                          suppress_data,
    input  wire mem_stage_pkg::word_t    bus_rdata,
    input  wire                          bus_busy,
    input  wire                          bus_error,
    input  wire                          iflush_done,
    input  wire                          dflush_done,
    output logic                         bus_ren,
    output logic                         bus_wen,
    output mem_stage_pkg::word_t         bus_addr,
    output mem_stage_pkg::word_t         bus_wdata,
    output mem_stage_pkg::byte_en_t      bus_byte_en,
    output logic                         icache_flush,
    output logic                         dcache_flush,
    output logic                         mem_busy,
    output logic                         fence_stall,
    output logic                         mal_l,
    output logic                         mal_s,
    output logic                         fault_l,
    output logic                         fault_s,
    output mem_stage_pkg::word_t         badaddr,
    output mem_stage_pkg::reg_idx_t      rd,
    output logic                         reg_write,
    output mem_stage_pkg::word_t         reg_wdata
);
    import mem_stage_pkg::*;

    word_t dload_ext;
    logic  misaligned;
    logic  req_ok;
    logic  flush_start;

    mem_access_unit access_unit (
        .access     (access),
        .addr_low   (alu_out[1:0]),
        .store_data (rs2_data),
        .load_word  (bus_rdata),
        .byte_en    (bus_byte_en),
        .bus_wdata  (bus_wdata),
        .misaligned (misaligned),
        .load_data  (dload_ext)
    );

    // Misaligned accesses are flagged, never issued
    assign req_ok   = !suppress_data && !misaligned;
    assign bus_ren  = dren && req_ok;
    assign bus_wen  = dwen && req_ok;
    assign bus_addr = alu_out;
    assign mem_busy = bus_busy;

    // Exception flags
    assign mal_l   = dren && misaligned;
    assign mal_s   = dwen && misaligned;
    assign fault_l = dren && bus_error;
    assign fault_s = dwen && bus_error;
    assign badaddr = alu_out;

    // Fence handling; both caches flush together
    fence_flush_ctrl fence_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .ifence      (ifence),
        .iflush_done (iflush_done),
        .dflush_done (dflush_done),
        .flush_start (flush_start),
        .fence_stall (fence_stall)
    );

    assign icache_flush = flush_start;
    assign dcache_flush = flush_start;

    // Writeback
    assign rd        = rd_in;
    assign reg_write = reg_write_in && !suppress_data;

    always_comb begin
        case (w_sel)
            WSEL_DLOAD: reg_wdata = dload_ext;
            WSEL_PC4:   reg_wdata = pc4;
            WSEL_IMM_U: reg_wdata = imm_u;
            WSEL_ALU:   reg_wdata = alu_out;
            default:    reg_wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // Basic datapath types
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [4:0]  reg_idx_t;

    // Access width as decoded from funct3
    // Stores only use LB, LH and LW; LBU/LHU behave like LB/LH there
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        NO_ACCESS
    } access_t;

    // Source of the register writeback value
    typedef enum logic [1:0] {
        WSEL_DLOAD,
        WSEL_PC4,
        WSEL_IMM_U,
        WSEL_ALU
    } w_sel_t;

    // Data memory geometry, 64 words = 256 bytes
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // Wait states per access
    localparam int DMEM_WAIT  = 2;
    localparam int WAIT_CNT_W = $clog2(DMEM_WAIT + 1);

    // Icache sweep length; dcache takes twice as long (writeback)
    localparam int FLUSH_LINES = 8;
    localparam int FLUSH_CNT_W = $clog2(2 * FLUSH_LINES + 1);

endpackage

`default_nettype wire

//--- design/mem_subsystem_top.sv
`default_nettype none

module mem_subsystem_top (
    input  wire                          CLK,
    input  wire                          nRST,
    input  wire                          dren,
    input  wire                          dwen,
    input  wire mem_stage_pkg::access_t  access,
    input  wire mem_stage_pkg::word_t    alu_out,
    input  wire mem_stage_pkg::word_t    rs2_data,
    input  wire mem_stage_pkg::word_t    pc4,
    input  wire mem_stage_pkg::word_t    imm_u,
    input  wire mem_stage_pkg::w_sel_t   w_sel,
    input  wire mem_stage_pkg::reg_idx_t rd_in,
    input  wire                          reg_write_in,
    input  wire                          ifence,
    input  wire                          suppress_data,
    output logic                         mem_busy,
    output logic                         fence_stall,
    output logic                         mal_l,
    output logic                         mal_s,
    output logic                         fault_l,
    output logic                         fault_s,
    output mem_stage_pkg::word_t         badaddr,
    output mem_stage_pkg::reg_idx_t      rd,
    output logic                         reg_write,
    output mem_stage_pkg::word_t         reg_wdata
);
    import mem_stage_pkg::*;

    // Data bus
    logic     bus_ren, bus_wen, bus_busy, bus_error;
    word_t    bus_addr, bus_wdata, bus_rdata;
    byte_en_t bus_byte_en;

    // Cache flush handshake
    logic icache_flush, dcache_flush;
    logic iflush_done, dflush_done;

    mem_stage stage (
        .CLK           (CLK),
        .nRST          (nRST),
        .dren          (dren),
        .dwen          (dwen),
        .access        (access),
        .alu_out       (alu_out),
        .rs2_data      (rs2_data),
        .pc4           (pc4),
        .imm_u         (imm_u),
        .w_sel         (w_sel),
        .rd_in         (rd_in),
        .reg_write_in  (reg_write_in),
        .ifence        (ifence),
        .suppress_data (suppress_data),
        .bus_rdata     (bus_rdata),
        .bus_busy      (bus_busy),
        .bus_error     (bus_error),
        .iflush_done   (iflush_done),
        .dflush_done   (dflush_done),
        .bus_ren       (bus_ren),
        .bus_wen       (bus_wen),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_byte_en   (bus_byte_en),
        .icache_flush  (icache_flush),
        .dcache_flush  (dcache_flush),
        .mem_busy      (mem_busy),
        .fence_stall   (fence_stall),
        .mal_l         (mal_l),
        .mal_s         (mal_s),
        .fault_l       (fault_l),
        .fault_s       (fault_s),
        .badaddr       (badaddr),
        .rd            (rd),
        .reg_write     (reg_write),
        .reg_wdata     (reg_wdata)
    );

    dmem_bank dmem (
        .CLK     (CLK),
        .nRST    (nRST),
        .ren     (bus_ren),
        .wen     (bus_wen),
        .addr    (bus_addr),
        .wdata   (bus_wdata),
        .byte_en (bus_byte_en),
        .rdata   (bus_rdata),
        .busy    (bus_busy),
        .error   (bus_error)
    );

    flush_line_counter flush_cnt (
        .CLK          (CLK),
        .nRST         (nRST),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done)
    );

endmodule

`default_nettype wire

//--- dv/mem_vectors.svh
`ifndef MEM_VECTORS_SVH
`define MEM_VECTORS_SVH

// Columns: access, {dren, dwen, suppress_data}, address, store data, w_sel,
// expected reg_wdata, expected {mal_l, mal_s, fault_l, fault_s}
typedef struct packed {
    access_t    access;
    logic [2:0] ctl;
    word_t      addr;
    word_t      wdata;
    w_sel_t     w_sel;
    word_t      exp_data;
    logic [3:0] exp_flags;
} vec_t;

localparam word_t PC4_VAL   = 32'h0000_0104;
localparam word_t IMM_U_VAL = 32'h1234_5000;

localparam int NUM_VECS = 40;

localparam vec_t VECS [NUM_VECS] = '{
    '{LW,        3'b010, 32'h0000_0000, 32'h8bad_f00d, WSEL_ALU,   32'h0000_0000, 4'b0000},
    '{LW,        3'b010, 32'h0000_0004, 32'h7f80_017e, WSEL_ALU,   32'h0000_0004, 4'b0000},
    '{LW,        3'b100, 32'h0000_0000, 32'h0000_0000, WSEL_DLOAD, 32'h8bad_f00d, 4'b0000},
    '{LB,        3'b100, 32'h0000_0000, 32'h0000_0000, WSEL_DLOAD, 32'h0000_000d, 4'b0000},
    '{LB,        3'b100, 32'h0000_0001, 32'h0000_0000, WSEL_DLOAD, 32'hffff_fff0, 4'b0000},
    '{LB,        3'b100, 32'h0000_0002, 32'h0000_0000, WSEL_DLOAD, 32'hffff_ffad, 4'b0000},
    '{LB,        3'b100, 32'h0000_0003, 32'h0000_0000, WSEL_DLOAD, 32'hffff_ff8b, 4'b0000},
    '{LBU,       3'b100, 32'h0000_0001, 32'h0000_0000, WSEL_DLOAD, 32'h0000_00f0, 4'b0000},
    '{LBU,       3'b100, 32'h0000_0003, 32'h0000_0000, WSEL_DLOAD, 32'h0000_008b, 4'b0000},
    '{LH,        3'b100, 32'h0000_0000, 32'h0000_0000, WSEL_DLOAD, 32'hffff_f00d, 4'b0000},
    '{LH,        3'b100, 32'h0000_0002, 32'h0000_0000, WSEL_DLOAD, 32'hffff_8bad, 4'b0000},
    '{LHU,       3'b100, 32'h0000_0002, 32'h0000_0000, WSEL_DLOAD, 32'h0000_8bad, 4'b0000},
    '{LB,        3'b100, 32'h0000_0004, 32'h0000_0000, WSEL_DLOAD, 32'h0000_007e, 4'b0000},
    '{LB,        3'b100, 32'h0000_0006, 32'h0000_0000, WSEL_DLOAD, 32'hffff_ff80, 4'b0000},
    '{LBU,       3'b100, 32'h0000_0006, 32'h0000_0000, WSEL_DLOAD, 32'h0000_0080, 4'b0000},
    '{LH,        3'b100, 32'h0000_0004, 32'h0000_0000, WSEL_DLOAD, 32'h0000_017e, 4'b0000},
    '{LHU,       3'b100, 32'h0000_0006, 32'h0000_0000, WSEL_DLOAD, 32'h0000_7f80, 4'b0000},
    '{LW,        3'b100, 32'h0000_0004, 32'h0000_0000, WSEL_DLOAD, 32'h7f80_017e, 4'b0000},
    // Partial stores build up the word at 0x08
    '{LB,        3'b010, 32'h0000_0009, 32'h1234_5655, WSEL_ALU,   32'h0000_0009, 4'b0000},
    '{LH,        3'b010, 32'h0000_000a, 32'h9876_c3a5, WSEL_ALU,   32'h0000_000a, 4'b0000},
    '{LB,        3'b010, 32'h0000_0008, 32'h0000_00aa, WSEL_ALU,   32'h0000_0008, 4'b0000},
    '{LW,        3'b100, 32'h0000_0008, 32'h0000_0000, WSEL_DLOAD, 32'hc3a5_55aa, 4'b0000},
    '{LBU,       3'b100, 32'h0000_000b, 32'h0000_0000, WSEL_DLOAD, 32'h0000_00c3, 4'b0000},
    '{LH,        3'b100, 32'h0000_000a, 32'h0000_0000, WSEL_DLOAD, 32'hffff_c3a5, 4'b0000},
    // Misaligned, word 0 has to survive the stores
    '{LH,        3'b100, 32'h0000_0005, 32'h0000_0000, WSEL_ALU,   32'h0000_0005, 4'b1000},
    '{LW,        3'b100, 32'h0000_0006, 32'h0000_0000, WSEL_ALU,   32'h0000_0006, 4'b1000},
    '{LHU,       3'b100, 32'h0000_0003, 32'h0000_0000, WSEL_ALU,   32'h0000_0003, 4'b1000},
    '{LH,        3'b010, 32'h0000_0001, 32'hffff_ffff, WSEL_ALU,   32'h0000_0001, 4'b0100},
    '{LW,        3'b010, 32'h0000_0002, 32'hffff_ffff, WSEL_ALU,   32'h0000_0002, 4'b0100},
    '{LW,        3'b100, 32'h0000_0000, 32'h0000_0000, WSEL_DLOAD, 32'h8bad_f00d, 4'b0000},
    // Out of range
    '{LW,        3'b100, 32'h0000_0100, 32'h0000_0000, WSEL_ALU,   32'h0000_0100, 4'b0010},
    '{LW,        3'b010, 32'h0000_0104, 32'h1111_1111, WSEL_ALU,   32'h0000_0104, 4'b0001},
    '{LB,        3'b010, 32'h0000_01f3, 32'h0000_0042, WSEL_ALU,   32'h0000_01f3, 4'b0001},
    // Suppressed accesses
    '{LW,        3'b011, 32'h0000_000c, 32'hdead_beef, WSEL_ALU,   32'h0000_000c, 4'b0000},
    '{LW,        3'b011, 32'h0000_0200, 32'hdead_beef, WSEL_ALU,   32'h0000_0200, 4'b0000},
    '{LW,        3'b101, 32'h0000_000c, 32'h0000_0000, WSEL_ALU,   32'h0000_000c, 4'b0000},
    '{LW,        3'b100, 32'h0000_000c, 32'h0000_0000, WSEL_DLOAD, 32'h0000_0000, 4'b0000},
    // Non-load writeback
    '{NO_ACCESS, 3'b000, 32'h0000_0abc, 32'h0000_0000, WSEL_PC4,   PC4_VAL,       4'b0000},
    '{NO_ACCESS, 3'b000, 32'h0000_0abc, 32'h0000_0000, WSEL_IMM_U, IMM_U_VAL,     4'b0000},
    '{NO_ACCESS, 3'b000, 32'h0000_0abc, 32'h0000_0000, WSEL_ALU,   32'h0000_0abc, 4'b0000}
};

`endif

//--- dv/tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_stage_pkg::*;

    `include "mem_vectors.svh"

    localparam access_t STORE_WIDTHS [3] = '{LB, LH, LW};

    logic     CLK;
    logic     nRST;
    logic     dren;
    logic     dwen;
    access_t  access;
    word_t    alu_out;
    word_t    rs2_data;
    word_t    pc4;
    word_t    imm_u;
    w_sel_t   w_sel;
    reg_idx_t rd_in;
    logic     reg_write_in;
    logic     ifence;
    logic     suppress_data;
    logic     mem_busy;
    logic     fence_stall;
    logic     mal_l;
    logic     mal_s;
    logic     fault_l;
    logic     fault_s;
    word_t    badaddr;
    reg_idx_t rd;
    logic     reg_write;
    word_t    reg_wdata;

    // Expected memory content with little-endian lanes
    word_t    shadow [DMEM_WORDS];
    word_t    rng_state;
    reg_idx_t rd_seq;

    mem_subsystem_top dut (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s expected 0x%h, got 0x%h",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s expected %b, got %b",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s expected %0d, got %0d",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s expected %b, got %b",
                                $time, name, exp, got));
        end
    endtask

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Lanes touched by an aligned access
    function automatic byte_en_t lanes_for(input access_t a, input logic [1:0] off);
        case (a)
            LB, LBU: return 4'b0001 << off;
            LH, LHU: return 4'b0011 << off;
            LW:      return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    task automatic store_model(input access_t a, input word_t addr, input word_t data);
        byte_en_t lanes;
        word_t    shifted;
        lanes   = lanes_for(a, addr[1:0]);
        shifted = data << {addr[1:0], 3'b000};
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                shadow[addr[DMEM_IDX_W+1:2]][8*b +: 8] = shifted[8*b +: 8];
            end
        end
    endtask

    // Drive one access, wait for completion and check every result
    task automatic do_access(input access_t a, input logic [2:0] ctl, input word_t addr,
                             input word_t data, input w_sel_t ws, input word_t exp_data,
                             input logic [3:0] exp_flags);
        int   waits;
        int   exp_waits;
        logic issued;
        logic in_range;
        dren          = ctl[2];
        dwen          = ctl[1];
        suppress_data = ctl[0];
        access        = a;
        alu_out       = addr;
        rs2_data      = data;
        w_sel         = ws;
        rd_in         = rd_seq;
        reg_write_in  = rd_seq[0];
        issued    = (ctl[2] || ctl[1]) && !ctl[0] && (exp_flags[3:2] == 2'b00);
        in_range  = (addr < 4 * DMEM_WORDS);
        exp_waits = (issued && in_range) ? DMEM_WAIT : 0;
        waits = 0;
        @(negedge CLK);
        while (mem_busy) begin
            waits++;
            if (waits > 4 * DMEM_WAIT) begin
                abort_run("Timeout: mem_busy stayed high during an access");
            end
            @(negedge CLK);
        end
        check_word("wait cycles", word_t'(waits), word_t'(exp_waits));
        check_flag("mal_l", mal_l, exp_flags[3]);
        check_flag("mal_s", mal_s, exp_flags[2]);
        check_flag("fault_l", fault_l, exp_flags[1]);
        check_flag("fault_s", fault_s, exp_flags[0]);
        check_word("badaddr", badaddr, addr);
        check_flag("reg_write", reg_write, rd_seq[0] && !ctl[0]);
        check_reg_idx("rd", rd, rd_seq);
        check_word("reg_wdata", reg_wdata, exp_data);
        if (issued && in_range) begin
            check_byte_en("bus_byte_en", dut.bus_byte_en, lanes_for(a, addr[1:0]));
            if (ctl[1]) begin
                store_model(a, addr, data);
            end
        end
        rd_seq++;
        @(posedge CLK);
        #2;
    endtask

    task automatic random_stores(input int count);
        access_t    width;
        logic [1:0] off;
        word_t      addr;
        for (int k = 0; k < count; k++) begin
            rng_state = xorshift32(rng_state);
            width = STORE_WIDTHS[k % 3];
            case (width)
                LB:      off = rng_state[1:0];
                LH:      off = {rng_state[1], 1'b0};
                default: off = 2'b00;
            endcase
            // Byte addresses 0x40 to 0x7f
            addr = 32'h40 + {26'h0, rng_state[5:2], 2'b00} + {30'h0, off};
            rng_state = xorshift32(rng_state);
            do_access(width, 3'b010, addr, rng_state, WSEL_ALU, addr, 4'b0000);
        end
    endtask

    task automatic run_fence(input int hold_cycles);
        int n;
        int stall;
        ifence = 1'b1;
        @(negedge CLK);
        check_flag("icache_flush", dut.icache_flush, 1'b1);
        check_flag("dcache_flush", dut.dcache_flush, 1'b1);
        n = 0;
        while (!fence_stall) begin
            n++;
            if (n > 4) begin
                abort_run("Timeout: fence_stall never rose after ifence");
            end
            @(negedge CLK);
        end
        check_word("fence_stall start delay", word_t'(n), word_t'(1));
        // Flush request is a single-cycle pulse
        check_flag("icache_flush", dut.icache_flush, 1'b0);
        check_flag("dcache_flush", dut.dcache_flush, 1'b0);
        stall = 0;
        while (fence_stall) begin
            stall++;
            if (stall > 4 * FLUSH_LINES) begin
                abort_run("Timeout: fence_stall did not drop after the flushes");
            end
            @(negedge CLK);
        end
        check_word("fence_stall cycles", word_t'(stall), word_t'(2 * FLUSH_LINES));
        // No second flush while ifence stays high
        repeat (hold_cycles) begin
            check_flag("fence_stall", fence_stall, 1'b0);
            check_flag("icache_flush", dut.icache_flush, 1'b0);
            @(negedge CLK);
        end
        @(posedge CLK);
        #2;
        ifence = 1'b0;
        @(posedge CLK);
        #2;
    endtask

    initial begin
        nRST          = 1'b0;
        dren          = 1'b0;
        dwen          = 1'b0;
        access        = NO_ACCESS;
        alu_out       = '0;
        rs2_data      = '0;
        pc4           = PC4_VAL;
        imm_u         = IMM_U_VAL;
        w_sel         = WSEL_ALU;
        rd_in         = '0;
        reg_write_in  = 1'b1;
        ifence        = 1'b0;
        suppress_data = 1'b0;
        rng_state     = 32'hd7f;
        rd_seq        = '0;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            shadow[w] = '0;
        end

        repeat (2) @(posedge CLK);
        #2;
        nRST = 1'b1;

        // Control outputs idle out of reset
        @(negedge CLK);
        check_flag("mem_busy", mem_busy, 1'b0);
        check_flag("fence_stall", fence_stall, 1'b0);
        check_flag("mal_l", mal_l, 1'b0);
        check_flag("mal_s", mal_s, 1'b0);
        check_flag("fault_l", fault_l, 1'b0);
        check_flag("fault_s", fault_s, 1'b0);
        check_flag("icache_flush", dut.icache_flush, 1'b0);
        check_flag("dcache_flush", dut.dcache_flush, 1'b0);
        @(posedge CLK);
        #2;

        for (int i = 0; i < NUM_VECS; i++) begin
            do_access(VECS[i].access, VECS[i].ctl, VECS[i].addr, VECS[i].wdata,
                      VECS[i].w_sel, VECS[i].exp_data, VECS[i].exp_flags);
        end

        random_stores(24);

        // Whole memory against the model
        for (int w = 0; w < DMEM_WORDS; w++) begin
            do_access(LW, 3'b100, word_t'(4 * w), '0, WSEL_DLOAD, shadow[w], 4'b0000);
        end

        dren = 1'b0;
        dwen = 1'b0;
        run_fence(3 * FLUSH_LINES);
        run_fence(2);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
design/mem_stage_pkg.sv
design/mem_access_unit.sv
design/fence_flush_ctrl.sv
design/flush_line_counter.sv
design/dmem_bank.sv
design/mem_stage.sv
design/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv
